// File: hw/im2col_pkg.sv
// Width constants, layer configuration, DMA descriptor and generator state types
package im2col_pkg;

  localparam int unsigned PTR_W  = 32;  // Address width
  localparam int unsigned INC_W  = 23;  // Second-dimension source increment
  localparam int unsigned ZERO_W = 8;
  localparam int unsigned SIZE_W = 16;

  // One convolution layer as handed over by the host
  typedef struct packed {
    logic [PTR_W-1:0] src_ptr;
    logic [PTR_W-1:0] dst_ptr;
    logic [15:0]      ih;
    logic [15:0]      iw;
    logic [7:0]       num_ch;
    logic [7:0]       batch;
    logic [7:0]       fh;
    logic [7:0]       fw;
    logic [5:0]       pad_top;
    logic [5:0]       pad_bottom;
    logic [5:0]       pad_left;
    logic [5:0]       pad_right;
    logic [7:0]       adpt_pad_bottom;
    logic [7:0]       adpt_pad_right;
    logic [3:0]       log_stride_d1;
    logic [3:0]       log_stride_d2;
    logic [15:0]      n_patches_h;
    logic [15:0]      n_patches_w;
    logic [15:0]      ch_col;         // num_ch * fh * fw
  } im2col_cfg_t;

  typedef struct packed {
    logic [PTR_W-1:0]  src_ptr;
    logic [PTR_W-1:0]  dst_ptr;
    logic [INC_W-1:0]  src_inc_d2;
    logic [ZERO_W-1:0] zeros_top;
    logic [ZERO_W-1:0] zeros_bottom;
    logic [ZERO_W-1:0] zeros_left;
    logic [ZERO_W-1:0] zeros_right;
    logic [SIZE_W-1:0] size_d1;
    logic [SIZE_W-1:0] size_d2;
    logic              last;
  } im2col_desc_t;

  typedef enum logic [3:0] {
    IDLE,
    ZEROS_PREP,
    ZEROS_SUB,
    ZEROS_SHIFT,
    INDEX_MUL1,
    INDEX_MUL2,
    WAIT_SPACE,
    PUSH,
    ADVANCE_BATCH,
    ADVANCE_OFFSET
  } gen_state_e;

endpackage

// File: hw/im2col_push_if.sv
// Write channel from the parameter generator into the descriptor FIFO
`timescale 1ns/1ps

interface im2col_push_if;

  logic                     push;  // One descriptor per cycle high
  logic                     full;
  im2col_pkg::im2col_desc_t desc;
  logic                     last;  // Final descriptor of the layer

  // Generator side
  modport producer (
    output push,
    output desc,
    output last,
    input  full
  );

  // FIFO side
  modport consumer (
    input  push,
    input  desc,
    input  last,
    output full
  );

endinterface

// File: hw/im2col_cfg_capture.sv
// Four-phase layer configuration intake with latched config and start pulse
`timescale 1ns/1ps

module im2col_cfg_capture (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_req_i,
  input  im2col_pkg::im2col_cfg_t cfg_i,
  input  logic                    gen_idle_i,
  output logic                    cfg_ack_o,
  output logic                    start_o,
  output im2col_pkg::im2col_cfg_t cfg_o
);

  typedef enum logic {
    CAP_WAIT_REQ,
    CAP_WAIT_DROP
  } cap_state_e;

  cap_state_e state_q;
  logic       accept;

  // Take a layer only when nothing is running
  assign accept    = (state_q == CAP_WAIT_REQ) && cfg_req_i && gen_idle_i;
  assign cfg_ack_o = (state_q == CAP_WAIT_DROP);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CAP_WAIT_REQ;
      start_o <= 1'b0;
    end else begin
      start_o <= accept;  // Single cycle, config already latched
      if (accept) begin
        state_q <= CAP_WAIT_DROP;
      end else if (state_q == CAP_WAIT_DROP && !cfg_req_i) begin
        state_q <= CAP_WAIT_REQ;
      end
    end
  end

  // Held for the whole run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      cfg_o <= cfg_i;
    end
  end

endmodule

// File: hw/im2col_param_gen.sv
// Loop-nest FSM and pipelined DMA descriptor arithmetic for im2col
`timescale 1ns/1ps

module im2col_param_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  im2col_pkg::im2col_cfg_t cfg_i,
  output logic                    idle_o,
  im2col_push_if.producer         push_o
);

  im2col_pkg::gen_state_e state_q, state_d;

  // Loop counters, batch innermost
  logic [7:0]  batch_cnt_q;
  logic [7:0]  w_off_q;
  logic [7:0]  h_off_q;
  logic [7:0]  ch_q;
  logic [15:0] ch_col_cnt_q;
  logic [im2col_pkg::PTR_W-1:0] dst_ptr_q;

  // Pipeline registers
  logic [7:0] fw_min_w_q, fh_min_h_q;
  logic [7:0] diff_l_q, diff_t_q, diff_r_q, diff_b_q;
  logic [7:0] zeros_l_q, zeros_t_q, zeros_r_q, zeros_b_q;
  logic [im2col_pkg::PTR_W-1:0] idx_base_q, idx_row_q, idx_q;

  logic [im2col_pkg::PTR_W-1:0] im_row, im_col, src_inc, out_inc;
  logic [15:0] size_d1, size_d2;
  logic        batch_end, ch_col_end, last_point;
  im2col_pkg::im2col_desc_t desc;

  // Division by a power-of-two stride, rounded up
  function automatic logic [7:0] ceil_shift(input logic [7:0] val, input logic [3:0] sh);
    logic [7:0] mask;
    mask = (8'd1 << sh) - 8'd1;
    return (val >> sh) + {7'd0, |(val & mask)};
  endfunction

  assign batch_end  = (batch_cnt_q == cfg_i.batch - 8'd1);
  assign ch_col_end = (ch_col_cnt_q == cfg_i.ch_col - 16'd1);
  assign last_point = batch_end && ch_col_end;
  assign idle_o     = (state_q == im2col_pkg::IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      im2col_pkg::IDLE:           if (start_i) state_d = im2col_pkg::ZEROS_PREP;
      im2col_pkg::ZEROS_PREP:     state_d = im2col_pkg::ZEROS_SUB;
      im2col_pkg::ZEROS_SUB:      state_d = im2col_pkg::ZEROS_SHIFT;
      im2col_pkg::ZEROS_SHIFT:    state_d = im2col_pkg::INDEX_MUL1;
      im2col_pkg::INDEX_MUL1:     state_d = im2col_pkg::INDEX_MUL2;
      im2col_pkg::INDEX_MUL2:     state_d = im2col_pkg::WAIT_SPACE;
      im2col_pkg::WAIT_SPACE:     if (!push_o.full) state_d = im2col_pkg::PUSH;
      im2col_pkg::PUSH:           state_d = im2col_pkg::ADVANCE_BATCH;
      im2col_pkg::ADVANCE_BATCH: begin
        state_d = batch_end ? im2col_pkg::ADVANCE_OFFSET : im2col_pkg::ZEROS_PREP;
      end
      im2col_pkg::ADVANCE_OFFSET: begin
        state_d = ch_col_end ? im2col_pkg::IDLE : im2col_pkg::ZEROS_PREP;
      end
      default:                    state_d = im2col_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= im2col_pkg::IDLE;
      batch_cnt_q  <= '0;
      w_off_q      <= '0;
      h_off_q      <= '0;
      ch_q         <= '0;
      ch_col_cnt_q <= '0;
      dst_ptr_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == im2col_pkg::IDLE && start_i) begin
        batch_cnt_q  <= '0;
        w_off_q      <= '0;
        h_off_q      <= '0;
        ch_q         <= '0;
        ch_col_cnt_q <= '0;
        dst_ptr_q    <= cfg_i.dst_ptr;
      end
      if (state_q == im2col_pkg::ADVANCE_BATCH) begin
        dst_ptr_q   <= dst_ptr_q + out_inc;  // One output plane per descriptor
        batch_cnt_q <= batch_end ? 8'd0 : batch_cnt_q + 8'd1;
      end
      if (state_q == im2col_pkg::ADVANCE_OFFSET) begin
        ch_col_cnt_q <= ch_col_cnt_q + 16'd1;
        if (w_off_q == cfg_i.fw - 8'd1) begin
          w_off_q <= '0;
          if (h_off_q == cfg_i.fh - 8'd1) begin
            h_off_q <= '0;
            ch_q    <= ch_q + 8'd1;
          end else begin
            h_off_q <= h_off_q + 8'd1;
          end
        end else begin
          w_off_q <= w_off_q + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      im2col_pkg::ZEROS_PREP: begin
        fw_min_w_q <= cfg_i.fw - 8'd1 - w_off_q;
        fh_min_h_q <= cfg_i.fh - 8'd1 - h_off_q;
        idx_base_q <= 32'(batch_cnt_q) * 32'(cfg_i.num_ch) + 32'(ch_q);
      end
      im2col_pkg::ZEROS_SUB: begin
        diff_l_q <= 8'(cfg_i.pad_left) - w_off_q;
        diff_t_q <= 8'(cfg_i.pad_top) - h_off_q;
        diff_r_q <= cfg_i.adpt_pad_right - fw_min_w_q;
        diff_b_q <= cfg_i.adpt_pad_bottom - fh_min_h_q;
      end
      im2col_pkg::ZEROS_SHIFT: begin
        zeros_l_q <= (w_off_q >= 8'(cfg_i.pad_left)) ? 8'd0
                     : ceil_shift(diff_l_q, cfg_i.log_stride_d1);
        zeros_t_q <= (h_off_q >= 8'(cfg_i.pad_top)) ? 8'd0
                     : ceil_shift(diff_t_q, cfg_i.log_stride_d2);
        zeros_r_q <= (fw_min_w_q >= 8'(cfg_i.pad_right) || cfg_i.adpt_pad_right == 8'd0) ? 8'd0
                     : ceil_shift(diff_r_q, cfg_i.log_stride_d1);
        zeros_b_q <= (fh_min_h_q >= 8'(cfg_i.pad_bottom) || cfg_i.adpt_pad_bottom == 8'd0) ? 8'd0
                     : ceil_shift(diff_b_q, cfg_i.log_stride_d2);
      end
      im2col_pkg::INDEX_MUL1: begin
        idx_row_q <= idx_base_q * 32'(cfg_i.ih) + im_row
                     + (32'(zeros_t_q) << cfg_i.log_stride_d2);
      end
      im2col_pkg::INDEX_MUL2: begin
        idx_q <= idx_row_q * 32'(cfg_i.iw) + im_col
                 + (32'(zeros_l_q) << cfg_i.log_stride_d1);
      end
      default: ;
    endcase
  end

  // Offsets relative to the padded origin, may wrap negative
  assign im_row  = 32'(h_off_q) - 32'(cfg_i.pad_top);
  assign im_col  = 32'(w_off_q) - 32'(cfg_i.pad_left);
  assign size_d1 = cfg_i.n_patches_w - 16'(zeros_l_q) - 16'(zeros_r_q);
  assign size_d2 = cfg_i.n_patches_h - 16'(zeros_t_q) - 16'(zeros_b_q);
  assign src_inc = (32'(cfg_i.iw) << cfg_i.log_stride_d2)
                   - ((32'(size_d1) - 32'd1) << cfg_i.log_stride_d1);
  assign out_inc = (32'(cfg_i.n_patches_h) * 32'(cfg_i.n_patches_w)) << 2;

  always_comb begin
    desc.src_ptr      = cfg_i.src_ptr + (idx_q << 2);  // Word addressed
    desc.dst_ptr      = dst_ptr_q;
    desc.src_inc_d2   = src_inc[im2col_pkg::INC_W-1:0];
    desc.zeros_top    = zeros_t_q;
    desc.zeros_bottom = zeros_b_q;
    desc.zeros_left   = zeros_l_q;
    desc.zeros_right  = zeros_r_q;
    desc.size_d1      = size_d1;
    desc.size_d2      = size_d2;
    desc.last         = last_point;
  end

  assign push_o.push = (state_q == im2col_pkg::PUSH);
  assign push_o.desc = desc;
  assign push_o.last = last_point;

endmodule

// File: hw/im2col_desc_fifo.sv
// Circular descriptor FIFO with occupancy count, full and empty flags
`timescale 1ns/1ps

module im2col_desc_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  im2col_push_if.consumer          push_i,
  input  logic                     pop_i,
  output logic                     empty_o,
  output im2col_pkg::im2col_desc_t rd_desc_o
);

  localparam int unsigned IDX_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned SUM_W = CNT_W + 1;

  im2col_pkg::im2col_desc_t mem_q [FIFO_DEPTH];
  im2col_pkg::im2col_desc_t wr_entry;
  logic [IDX_W-1:0] rd_ptr_q;
  logic [IDX_W-1:0] wr_idx;
  logic [CNT_W-1:0] cnt_q;
  logic [SUM_W-1:0] wr_sum;
  logic             do_write;
  logic             do_read;

  assign push_i.full = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign empty_o     = (cnt_q == '0);
  assign do_write    = push_i.push && !push_i.full;
  assign do_read     = pop_i && !empty_o;

  // Write slot sits count entries past the read pointer
  assign wr_sum = SUM_W'(rd_ptr_q) + SUM_W'(cnt_q);
  assign wr_idx = (wr_sum >= SUM_W'(FIFO_DEPTH)) ? IDX_W'(wr_sum - SUM_W'(FIFO_DEPTH))
                                                 : IDX_W'(wr_sum);

  always_comb begin
    wr_entry      = push_i.desc;
    wr_entry.last = push_i.last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_read) begin
        rd_ptr_q <= (rd_ptr_q == IDX_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_write && !do_read) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_read && !do_write) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_idx] <= wr_entry;
    end
  end

  assign rd_desc_o = mem_q[rd_ptr_q];  // Head entry, valid when not empty

endmodule

// File: hw/im2col_desc_out.sv
// Four-phase descriptor output port that pops the FIFO and flags run end
`timescale 1ns/1ps

module im2col_desc_out (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     empty_i,
  input  im2col_pkg::im2col_desc_t rd_desc_i,
  input  logic                     desc_ack_i,
  output logic                     pop_o,
  output logic                     desc_req_o,
  output im2col_pkg::im2col_desc_t desc_o,
  output logic                     busy_clear_o
);

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,   // Request up, waiting for ack
    OUT_DROP   // Request down, waiting for ack low
  } out_state_e;

  out_state_e               state_q;
  im2col_pkg::im2col_desc_t desc_q;

  // Never start a new request while the previous ack is still high
  assign pop_o        = (state_q == OUT_IDLE) && !empty_i && !desc_ack_i;
  assign desc_req_o   = (state_q == OUT_REQ);
  assign desc_o       = desc_q;
  assign busy_clear_o = (state_q == OUT_REQ) && desc_ack_i && desc_q.last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= OUT_IDLE;
    end else begin
      case (state_q)
        OUT_IDLE: if (pop_o) state_q <= OUT_REQ;
        OUT_REQ:  if (desc_ack_i) state_q <= OUT_DROP;
        OUT_DROP: if (!desc_ack_i) state_q <= OUT_IDLE;
        default:  state_q <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      desc_q <= rd_desc_i;  // Held stable for the whole handshake
    end
  end

endmodule

// File: hw/im2col_top.sv
// im2col parameter engine top level with config intake, generator and descriptor output
`timescale 1ns/1ps

module im2col_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     cfg_req_i,
  input  im2col_pkg::im2col_cfg_t  cfg_i,
  output logic                     cfg_ack_o,
  output logic                     desc_req_o,
  output im2col_pkg::im2col_desc_t desc_o,
  input  logic                     desc_ack_i,
  output logic                     busy_o
);

  im2col_push_if push_if ();

  im2col_pkg::im2col_cfg_t  cfg_q;
  im2col_pkg::im2col_desc_t fifo_desc;
  logic start;
  logic gen_idle;
  logic fifo_empty;
  logic fifo_pop;
  logic busy_clear;
  logic busy_q;

  // New layers wait until the output side has drained too
  im2col_cfg_capture u_capture (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_req_i  (cfg_req_i),
    .cfg_i      (cfg_i),
    .gen_idle_i (gen_idle && !busy_q),
    .cfg_ack_o  (cfg_ack_o),
    .start_o    (start),
    .cfg_o      (cfg_q)
  );

  im2col_param_gen u_gen (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start),
    .cfg_i   (cfg_q),
    .idle_o  (gen_idle),
    .push_o  (push_if.producer)
  );

  im2col_desc_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .push_i    (push_if.consumer),
    .pop_i     (fifo_pop),
    .empty_o   (fifo_empty),
    .rd_desc_o (fifo_desc)
  );

  im2col_desc_out u_out (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .empty_i      (fifo_empty),
    .rd_desc_i    (fifo_desc),
    .desc_ack_i   (desc_ack_i),
    .pop_o        (fifo_pop),
    .desc_req_o   (desc_req_o),
    .desc_o       (desc_o),
    .busy_clear_o (busy_clear)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (busy_clear) begin
      busy_q <= 1'b0;  // Last descriptor acknowledged
    end
  end

  assign busy_o = busy_q;

endmodule

// File: sim/im2col_assertions.sv
// Concurrent handshake and write channel assertions bound into im2col_top
`timescale 1ns/1ps

module im2col_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     cfg_req_i,
  input logic                     cfg_ack_i,
  input logic                     desc_req_i,
  input logic                     desc_ack_i,
  input im2col_pkg::im2col_desc_t desc_i,
  input logic                     push_i,
  input logic                     full_i
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run

  // Descriptor held while the request waits for its ack
  desc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    desc_req_i && !desc_ack_i |=> $stable(desc_i))
    else begin
      $error("desc_o changed while the request was pending");
      fail_cnt++;
    end

  req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(desc_req_i) |-> !$past(desc_ack_i))
    else begin
      $error("desc_req_o rose while desc_ack_i was still high");
      fail_cnt++;
    end

  cfg_ack_on_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_ack_i) |-> $past(cfg_req_i))
    else begin
      $error("cfg_ack_o rose without a pending cfg_req_i");
      fail_cnt++;
    end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_i)
    else begin
      $error("descriptor pushed into a full FIFO");
      fail_cnt++;
    end

endmodule

bind im2col_top im2col_assertions u_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .cfg_req_i  (cfg_req_i),
  .cfg_ack_i  (cfg_ack_o),
  .desc_req_i (desc_req_o),
  .desc_ack_i (desc_ack_i),
  .desc_i     (desc_o),
  .push_i     (push_if.push),
  .full_i     (push_if.full)
);

// File: sim/im2col_checker.sv
// Descriptor reference model, expected queue and field by field comparison
`timescale 1ns/1ps

module im2col_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     desc_req_i,
  input logic                     desc_ack_i,
  input im2col_pkg::im2col_desc_t desc_i
);

  im2col_pkg::im2col_desc_t exp_q[$];
  int    test_q[$];  // Test index of each expected descriptor
  string names[$];
  int    got_q[$];
  int    bad_q[$];
  int    err_cnt  = 0;
  int    desc_cnt = 0;

  // Ceiling of diff over 2**ls
  function automatic logic [7:0] ceil_div_pow2(input logic [7:0] diff, input logic [3:0] ls);
    return 8'((int'(diff) + (1 << ls) - 1) >> ls);
  endfunction

  task automatic load(input string name, input im2col_pkg::im2col_cfg_t c);
    im2col_pkg::im2col_desc_t d;
    logic [31:0] idx, inc, plane, last_idx, next_idx;
    logic [7:0]  fwm, fhm;
    int          top_row, left_col;
    int          k;
    k     = 0;
    plane = 32'(c.n_patches_h) * 32'(c.n_patches_w) * 32'd4;
    names.push_back(name);
    got_q.push_back(0);
    bad_q.push_back(0);
    // Channel, filter row, filter column, batch innermost
    for (int ch = 0; ch < int'(c.num_ch); ch++) begin
      for (int h = 0; h < int'(c.fh); h++) begin
        for (int w = 0; w < int'(c.fw); w++) begin
          for (int b = 0; b < int'(c.batch); b++) begin
            fwm = 8'(int'(c.fw) - 1 - w);
            fhm = 8'(int'(c.fh) - 1 - h);
            d.zeros_left = (w >= int'(c.pad_left)) ? 8'd0
                           : ceil_div_pow2(8'(int'(c.pad_left) - w), c.log_stride_d1);
            d.zeros_top = (h >= int'(c.pad_top)) ? 8'd0
                          : ceil_div_pow2(8'(int'(c.pad_top) - h), c.log_stride_d2);
            d.zeros_right = (fwm >= 8'(c.pad_right) || c.adpt_pad_right == 8'd0) ? 8'd0
                            : ceil_div_pow2(c.adpt_pad_right - fwm, c.log_stride_d1);
            d.zeros_bottom = (fhm >= 8'(c.pad_bottom) || c.adpt_pad_bottom == 8'd0) ? 8'd0
                             : ceil_div_pow2(c.adpt_pad_bottom - fhm, c.log_stride_d2);
            // First image row and column the transfer touches
            top_row  = h - int'(c.pad_top) + int'(d.zeros_top) * (1 << c.log_stride_d2);
            left_col = w - int'(c.pad_left) + int'(d.zeros_left) * (1 << c.log_stride_d1);
            idx = 32'(((b * int'(c.num_ch) + ch) * int'(c.ih) + top_row) * int'(c.iw)
                      + left_col);
            d.src_ptr = c.src_ptr + idx * 32'd4;
            d.dst_ptr = c.dst_ptr + 32'(k) * plane;
            d.size_d1 = c.n_patches_w - 16'(d.zeros_left) - 16'(d.zeros_right);
            d.size_d2 = c.n_patches_h - 16'(d.zeros_top) - 16'(d.zeros_bottom);
            // Step from the last element of a row to the first of the next one
            last_idx = idx + 32'((int'(d.size_d1) - 1) * (1 << c.log_stride_d1));
            next_idx = idx + 32'(int'(c.iw) * (1 << c.log_stride_d2));
            inc      = next_idx - last_idx;
            d.src_inc_d2 = inc[22:0];
            d.last = (ch == int'(c.num_ch) - 1) && (h == int'(c.fh) - 1)
                     && (w == int'(c.fw) - 1) && (b == int'(c.batch) - 1);
            exp_q.push_back(d);
            test_q.push_back(names.size() - 1);
            k++;
          end
        end
      end
    end
  endtask

  task automatic check_field(input int tid, input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("CHECK FAILED %s %s expected %h actual %h", names[tid], field, exp_v, act_v);
      err_cnt++;
      bad_q[tid]++;
    end
  endtask

  task automatic compare_desc(input im2col_pkg::im2col_desc_t act);
    im2col_pkg::im2col_desc_t e;
    int tid;
    desc_cnt++;
    if (exp_q.size() == 0) begin
      $display("Unexpected descriptor from the DUT with nothing left to expect");
      err_cnt++;
      return;
    end
    e   = exp_q.pop_front();
    tid = test_q.pop_front();
    check_field(tid, "src_ptr", e.src_ptr, act.src_ptr);
    check_field(tid, "dst_ptr", e.dst_ptr, act.dst_ptr);
    check_field(tid, "src_inc_d2", 32'(e.src_inc_d2), 32'(act.src_inc_d2));
    check_field(tid, "zeros_top", 32'(e.zeros_top), 32'(act.zeros_top));
    check_field(tid, "zeros_bottom", 32'(e.zeros_bottom), 32'(act.zeros_bottom));
    check_field(tid, "zeros_left", 32'(e.zeros_left), 32'(act.zeros_left));
    check_field(tid, "zeros_right", 32'(e.zeros_right), 32'(act.zeros_right));
    check_field(tid, "size_d1", 32'(e.size_d1), 32'(act.size_d1));
    check_field(tid, "size_d2", 32'(e.size_d2), 32'(act.size_d2));
    check_field(tid, "last", 32'(e.last), 32'(act.last));
    got_q[tid]++;
    if (e.last) begin
      $display("test %s finished: %0d descriptors, %0d errors", names[tid], got_q[tid],
               bad_q[tid]);
    end
  endtask

  // One sample per handshake at the acked edge
  always @(posedge clk_i) begin
    if (rst_ni && desc_req_i && desc_ack_i) begin
      compare_desc(desc_i);
    end
  end

endmodule

// File: sim/im2col_tb.sv
// im2col testbench with clock, reset, layer table, config driver, random acks and timeout
`timescale 1ns/1ps

module im2col_tb;

  localparam int NUM_ROWS = 6;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     cfg_req_i;
  im2col_pkg::im2col_cfg_t  cfg_i;
  logic                     cfg_ack_o;
  logic                     desc_req_o;
  im2col_pkg::im2col_desc_t desc_o;
  logic                     desc_ack_i;
  logic                     busy_o;

  // Layer table with the expected descriptor count per row
  string                   names[NUM_ROWS];
  im2col_pkg::im2col_cfg_t cfgs[NUM_ROWS];
  int                      exp_cnt[NUM_ROWS];
  bit                      early[NUM_ROWS];  // Request made while the previous run is busy
  int                      n_rows = 0;

  logic [31:0] lfsr_q = 32'he4fa_aa07;
  int          tb_err = 0;
  int          cycle_cnt = 0;
  int          limit = 0;
  int          errors;

  always #4 clk_i = ~clk_i;

  im2col_top #(
    .FIFO_DEPTH (4)
  ) dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_req_i  (cfg_req_i),
    .cfg_i      (cfg_i),
    .cfg_ack_o  (cfg_ack_o),
    .desc_req_o (desc_req_o),
    .desc_o     (desc_o),
    .desc_ack_i (desc_ack_i),
    .busy_o     (busy_o)
  );

  im2col_checker u_check (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .desc_req_i (desc_req_o),
    .desc_ack_i (desc_ack_i),
    .desc_i     (desc_o)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Three bits, one LFSR step each
  task automatic draw_delay(output int d);
    d = 0;
    repeat (3) begin
      lfsr_q = lfsr_step(lfsr_q);
      d      = (d << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic add_row(input string name, input bit erly, input int cnt, input int ih,
                         input int iw, input int ch, input int b, input int fh, input int fw,
                         input int pt, input int pb, input int pl, input int pr, input int apb,
                         input int apr, input int ls1, input int ls2, input int nph,
                         input int npw);
    im2col_pkg::im2col_cfg_t c;
    c = '0;
    c.src_ptr = 32'h1000_0000 + (32'(n_rows) << 16);
    c.dst_ptr = 32'h8000_0000 + (32'(n_rows) << 16);
    c.ih = 16'(ih);
    c.iw = 16'(iw);
    c.num_ch = 8'(ch);
    c.batch = 8'(b);
    c.fh = 8'(fh);
    c.fw = 8'(fw);
    c.pad_top = 6'(pt);
    c.pad_bottom = 6'(pb);
    c.pad_left = 6'(pl);
    c.pad_right = 6'(pr);
    c.adpt_pad_bottom = 8'(apb);
    c.adpt_pad_right = 8'(apr);
    c.log_stride_d1 = 4'(ls1);
    c.log_stride_d2 = 4'(ls2);
    c.n_patches_h = 16'(nph);
    c.n_patches_w = 16'(npw);
    c.ch_col = 16'(ch * fh * fw);
    names[n_rows]   = name;
    cfgs[n_rows]    = c;
    exp_cnt[n_rows] = cnt;
    early[n_rows]   = erly;
    n_rows++;
  endtask

  // Four-phase config handshake, called on a falling edge
  task automatic send_cfg(input int i);
    cfg_i     = cfgs[i];
    cfg_req_i = 1'b1;
    do @(negedge clk_i); while (!cfg_ack_o);
    if (busy_o) begin
      $display("Layer %s was acked while the previous run was still busy", names[i]);
      tb_err++;
    end
    cfg_req_i = 1'b0;
    do @(negedge clk_i); while (cfg_ack_o);
  endtask

  // Descriptor ack responder with random delay
  always begin : ack_proc
    int dly;
    @(negedge clk_i);
    if (desc_req_o) begin
      draw_delay(dly);
      repeat (dly) @(negedge clk_i);
      desc_ack_i = 1'b1;
      while (desc_req_o) @(negedge clk_i);
      desc_ack_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (limit > 0 && cycle_cnt > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    rst_ni     = 1'b0;
    cfg_req_i  = 1'b0;
    cfg_i      = '0;
    desc_ack_i = 1'b0;
    //      name         early cnt ih iw ch b fh fw pt pb pl pr apb apr ls1 ls2 nph npw
    add_row("no_pad_s1",  0, 18, 8, 8, 2, 1, 3, 3, 0, 0, 0, 0, 0, 0, 0, 0, 6, 6);
    add_row("sym_pad",    0, 9,  6, 6, 1, 1, 3, 3, 1, 1, 1, 1, 1, 1, 0, 0, 6, 6);
    add_row("s2_pad",     0, 18, 8, 8, 2, 1, 3, 3, 1, 1, 1, 1, 1, 1, 1, 1, 4, 4);
    add_row("batch3",     1, 24, 5, 5, 2, 3, 2, 2, 0, 0, 0, 0, 0, 0, 0, 0, 4, 4);
    add_row("asym_adpt",  1, 18, 7, 9, 1, 2, 3, 3, 2, 1, 1, 2, 0, 1, 0, 1, 5, 9);
    add_row("one_ch_1x1", 0, 1,  4, 4, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 4, 4);
    limit = 100;
    for (int i = 0; i < n_rows; i++) limit += 40 * exp_cnt[i];
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < n_rows; i++) begin
      if (!early[i]) begin
        while (busy_o) @(negedge clk_i);
      end
      u_check.load(names[i], cfgs[i]);
      send_cfg(i);
    end
    while (busy_o) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    for (int i = 0; i < n_rows; i++) begin
      if (u_check.got_q[i] != exp_cnt[i]) begin
        $display("CHECK FAILED %s descriptor count expected %0d actual %0d", names[i],
                 exp_cnt[i], u_check.got_q[i]);
        tb_err++;
      end
    end
    if (u_check.exp_q.size() != 0) begin
      $display("%0d expected descriptors never left the DUT", u_check.exp_q.size());
      tb_err++;
    end
    errors = tb_err + u_check.err_cnt + dut0.u_assert.fail_cnt;
    $display("Summary: %0d tests, %0d descriptors, %0d errors", n_rows, u_check.desc_cnt,
             errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
hw/im2col_pkg.sv
hw/im2col_push_if.sv
hw/im2col_cfg_capture.sv
hw/im2col_param_gen.sv
hw/im2col_desc_fifo.sv
hw/im2col_desc_out.sv
hw/im2col_top.sv
sim/im2col_assertions.sv
sim/im2col_checker.sv
sim/im2col_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the im2col testbench with Verilator, verdict from the simulation log
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module im2col_tb \
  -f sources.f -o im2col_sim > build.log 2>&1 \
  && ./obj_dir/im2col_sim > sim.log 2>&1 \
  && ! grep -q "CHECKS FAILED" sim.log \
  && grep -q "ALL CHECKS PASSED" sim.log \
  && { cat sim.log; echo "Simulation passed"; exit 0; } \
  || { cat build.log sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
